//--- filelist.f
hdl/pe_pkg.sv
hdl/pe_mac_if.sv
hdl/operand_align.sv
hdl/mac_unit.sv
hdl/result_out.sv
hdl/pe_top.sv
verification/pe_clock_gen.sv
verification/pe_tb.sv

//--- hdl/mac_unit.sv
`timescale 1ns/1ps

module mac_unit (
  input  logic          clk,
  input  logic          rst_n,
  pe_mac_if.mac         mac,
  output pe_pkg::psum_t sum,
  output logic          push
);
  import pe_pkg::*;

  // Stage 1 product and flags
  psum_t product;
  logic  p_valid;
  logic  p_first;
  logic  p_last;

  // Stage 2 running sum
  psum_t acc;

  // Stage 1 valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p_valid <= 1'b0;
    end else begin
      p_valid <= mac.valid;
    end
  end

  // Signed multiply into a full width product
  always_ff @(posedge clk) begin
    if (mac.valid) begin
      product <= psum_t'($signed(mac.op_l) * $signed(mac.op_t));
      p_first <= mac.first;
      p_last  <= mac.last;
    end
  end

  // First pair restarts the sum
  always_ff @(posedge clk) begin
    if (p_valid) begin
      if (p_first) begin
        acc <= product;
      end else begin
        acc <= acc + product;
      end
    end
  end

  // Finished sum goes out with the new accumulator value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= p_valid && p_last;
    end
  end

  assign sum = acc;

  // Every push traces back to a last pair issued two cycles before
  a_push_source: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> $past(mac.valid && mac.last, 2)
  );

endmodule

//--- hdl/operand_align.sv
`timescale 1ns/1ps

module operand_align #(
  parameter int RESULT_DEPTH = pe_pkg::RESULT_DEPTH_DEFAULT
) (
  input  logic             clk,
  input  logic             rst_n,
  input  pe_pkg::operand_t l_tdata,
  input  logic             l_tvalid,
  output logic             l_tready,
  input  logic             l_tlast,
  input  pe_pkg::operand_t t_tdata,
  input  logic             t_tvalid,
  output logic             t_tready,
  input  logic             t_tlast,
  output pe_pkg::operand_t r_tdata,
  output logic             r_tvalid,
  input  logic             r_tready,
  output logic             r_tlast,
  output pe_pkg::operand_t b_tdata,
  output logic             b_tvalid,
  input  logic             b_tready,
  output logic             b_tlast,
  input  logic             pop,
  pe_mac_if.issue          mac,
  output logic             err_unaligned
);
  import pe_pkg::*;

  credit_t credits;
  logic    first_pending;
  logic    pair_last;
  logic    r_free;
  logic    b_free;
  logic    credit_ok;
  logic    accept;
  logic    take;

  // Either side closing the vector ends it
  assign pair_last = l_tlast | t_tlast;

  // Holding register empty or emptied this cycle
  assign r_free = !r_tvalid || r_tready;
  assign b_free = !b_tvalid || b_tready;

  // A last pair needs a reserved result slot
  assign credit_ok = !pair_last || (credits != '0);

  // Both beats go together or not at all
  assign accept = l_tvalid && t_tvalid && r_free && b_free && credit_ok;
  assign l_tready = accept;
  assign t_tready = accept;

  // Slot reserved when a last pair issues
  assign take = accept && pair_last;

  // Issue straight to the MAC stage
  assign mac.op_l  = l_tdata;
  assign mac.op_t  = t_tdata;
  assign mac.valid = accept;
  assign mac.first = first_pending;
  assign mac.last  = pair_last;

  // Right and bottom valid flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_tvalid <= 1'b0;
      b_tvalid <= 1'b0;
    end else begin
      if (accept) begin
        r_tvalid <= 1'b1;
      end else if (r_tready) begin
        r_tvalid <= 1'b0;
      end
      if (accept) begin
        b_tvalid <= 1'b1;
      end else if (b_tready) begin
        b_tvalid <= 1'b0;
      end
    end
  end

  // Forwarded beats, held until taken
  always_ff @(posedge clk) begin
    if (accept) begin
      r_tdata <= l_tdata;
      r_tlast <= l_tlast;
      b_tdata <= t_tdata;
      b_tlast <= t_tlast;
    end
  end

  // Next pair after a last starts a new vector
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      first_pending <= 1'b1;
    end else if (accept) begin
      first_pending <= pair_last;
    end
  end

  // Free slot count, take and return may coincide
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= credit_t'(RESULT_DEPTH);
    end else begin
      case ({take, pop})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_unaligned <= 1'b0;
    end else if (accept && (l_tlast != t_tlast)) begin
      err_unaligned <= 1'b1;
    end
  end

  // Pops from the result queue must match issued lasts
  // An underflow wraps above the depth and trips this too
  a_credit_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    credits <= credit_t'(RESULT_DEPTH)
  );

endmodule

//--- hdl/pe_mac_if.sv
`timescale 1ns/1ps

interface pe_mac_if;
  import pe_pkg::*;

  // One operand pair per cycle
  operand_t op_l;
  operand_t op_t;
  // Pair issued this cycle
  logic     valid;
  // Vector markers
  logic     first;
  logic     last;

  // Input side drives the pair
  modport issue (
    output op_l, op_t, valid, first, last
  );

  // Pipeline consumes it, never stalls
  modport mac (
    input op_l, op_t, valid, first, last
  );

endinterface

//--- hdl/pe_pkg.sv
package pe_pkg;

  // Operand width on the left and top streams
  localparam int OP_WIDTH = 16;

  // Accumulator holds one full product, wraps on overflow
  localparam int PSUM_WIDTH = 2 * OP_WIDTH;

  // Enough for result queues of up to 7 entries
  localparam int CREDIT_WIDTH = 3;

  // Default number of result queue entries
  localparam int RESULT_DEPTH_DEFAULT = 4;

  // Signed two's-complement operand
  typedef logic [OP_WIDTH-1:0] operand_t;

  // Accumulated dot product
  typedef logic [PSUM_WIDTH-1:0] psum_t;

  // Free result slots, 0 up to the queue depth
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

endpackage

//--- hdl/pe_top.sv
`timescale 1ns/1ps

module pe_top #(
  parameter int RESULT_DEPTH = pe_pkg::RESULT_DEPTH_DEFAULT
) (
  input  logic             clk,
  input  logic             rst_n,
  // Left in
  input  pe_pkg::operand_t s_axis_l_tdata,
  input  logic             s_axis_l_tvalid,
  output logic             s_axis_l_tready,
  input  logic             s_axis_l_tlast,
  // Top in
  input  pe_pkg::operand_t s_axis_t_tdata,
  input  logic             s_axis_t_tvalid,
  output logic             s_axis_t_tready,
  input  logic             s_axis_t_tlast,
  // Right out
  output pe_pkg::operand_t m_axis_r_tdata,
  output logic             m_axis_r_tvalid,
  input  logic             m_axis_r_tready,
  output logic             m_axis_r_tlast,
  // Bottom out
  output pe_pkg::operand_t m_axis_b_tdata,
  output logic             m_axis_b_tvalid,
  input  logic             m_axis_b_tready,
  output logic             m_axis_b_tlast,
  // Down out, finished dot products
  output pe_pkg::psum_t    m_axis_d_tdata,
  output logic             m_axis_d_tvalid,
  input  logic             m_axis_d_tready,
  output logic             m_axis_d_tlast,
  output logic             err_unaligned
);
  import pe_pkg::*;

  psum_t sum;
  logic  push;
  logic  pop;

  // Issued pairs from input side to MAC
  pe_mac_if mac_bus ();

  // Pairing, forwarding and credits
  operand_align #(
    .RESULT_DEPTH (RESULT_DEPTH)
  ) u_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .l_tdata       (s_axis_l_tdata),
    .l_tvalid      (s_axis_l_tvalid),
    .l_tready      (s_axis_l_tready),
    .l_tlast       (s_axis_l_tlast),
    .t_tdata       (s_axis_t_tdata),
    .t_tvalid      (s_axis_t_tvalid),
    .t_tready      (s_axis_t_tready),
    .t_tlast       (s_axis_t_tlast),
    .r_tdata       (m_axis_r_tdata),
    .r_tvalid      (m_axis_r_tvalid),
    .r_tready      (m_axis_r_tready),
    .r_tlast       (m_axis_r_tlast),
    .b_tdata       (m_axis_b_tdata),
    .b_tvalid      (m_axis_b_tvalid),
    .b_tready      (m_axis_b_tready),
    .b_tlast       (m_axis_b_tlast),
    .pop           (pop),
    .mac           (mac_bus.issue),
    .err_unaligned (err_unaligned)
  );

  // Multiply-accumulate
  mac_unit u_mac (
    .clk   (clk),
    .rst_n (rst_n),
    .mac   (mac_bus.mac),
    .sum   (sum),
    .push  (push)
  );

  // Result queue onto the down stream
  result_out #(
    .RESULT_DEPTH (RESULT_DEPTH)
  ) u_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .sum      (sum),
    .push     (push),
    .d_tdata  (m_axis_d_tdata),
    .d_tvalid (m_axis_d_tvalid),
    .d_tready (m_axis_d_tready),
    .d_tlast  (m_axis_d_tlast),
    .pop      (pop)
  );

endmodule

//--- hdl/result_out.sv
`timescale 1ns/1ps

module result_out #(
  parameter int RESULT_DEPTH = pe_pkg::RESULT_DEPTH_DEFAULT
) (
  input  logic          clk,
  input  logic          rst_n,
  input  pe_pkg::psum_t sum,
  input  logic          push,
  output pe_pkg::psum_t d_tdata,
  output logic          d_tvalid,
  input  logic          d_tready,
  output logic          d_tlast,
  output logic          pop
);
  import pe_pkg::*;

  localparam int PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
  localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

  psum_t            mem [RESULT_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Head entry drives the down stream
  assign d_tvalid = (count != '0);
  assign d_tdata  = mem[rd_ptr];
  // Every result is a one-beat packet
  assign d_tlast  = d_tvalid;

  // Completed down beat frees a slot
  assign pop = d_tvalid && d_tready;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= sum;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(RESULT_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(RESULT_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Credits upstream must keep the queue from overflowing
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> (count != CNT_W'(RESULT_DEPTH))
  );

endmodule

//--- verification/pe_clock_gen.sv
`timescale 1ns/1ps

module pe_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);
  // Power-on reset, released shortly after an edge
  logic por_n;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    por_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    por_n = 1'b1;
  end

  // Testbench may pull reset again later
  assign rst_n = por_n && !rst_req;

endmodule

//--- verification/pe_tb.sv
`timescale 1ns/1ps

module pe_tb;
  import pe_pkg::*;

  localparam int CLK_PERIOD = 40;
  // Pairs sent over all tests
  localparam int EXPECTED_BEATS  = 19;
  localparam int WATCHDOG_CYCLES = EXPECTED_BEATS * 50 + 200;

  logic     clk;
  logic     rst_n;
  logic     rst_req;
  operand_t s_axis_l_tdata;
  logic     s_axis_l_tvalid;
  logic     s_axis_l_tready;
  logic     s_axis_l_tlast;
  operand_t s_axis_t_tdata;
  logic     s_axis_t_tvalid;
  logic     s_axis_t_tready;
  logic     s_axis_t_tlast;
  operand_t m_axis_r_tdata;
  logic     m_axis_r_tvalid;
  logic     m_axis_r_tready;
  logic     m_axis_r_tlast;
  operand_t m_axis_b_tdata;
  logic     m_axis_b_tvalid;
  logic     m_axis_b_tready;
  logic     m_axis_b_tlast;
  psum_t    m_axis_d_tdata;
  logic     m_axis_d_tvalid;
  logic     m_axis_d_tready;
  logic     m_axis_d_tlast;
  logic     err_unaligned;

  integer seed = 44177;
  int     errors;
  int     tests_passed;
  int     tests_failed;

  // Observed beats as {tlast, tdata}
  logic [OP_WIDTH:0] r_q[$];
  logic [OP_WIDTH:0] b_q[$];
  psum_t             d_q[$];
  // Expected beats from the model
  logic [OP_WIDTH:0] exp_r[$];
  logic [OP_WIDTH:0] exp_b[$];
  psum_t             exp_d[$];
  // Dot product model state
  psum_t model_acc;
  bit    model_first;

  pe_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (8)
  ) u_clk (
    .rst_req (rst_req),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  pe_top DUT (.*);

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(bit cond, string what);
    assert (cond) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  // Signed 16x16 product wrapping at 32 bits
  function automatic psum_t signed_product(operand_t a, operand_t b);
    logic signed [PSUM_WIDTH-1:0] wa;
    logic signed [PSUM_WIDTH-1:0] wb;
    wa = $signed(a);
    wb = $signed(b);
    return wa * wb;
  endfunction

  // Sampled mid-cycle ahead of the transfer edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (m_axis_r_tvalid && m_axis_r_tready) begin
        r_q.push_back({m_axis_r_tlast, m_axis_r_tdata});
      end
      if (m_axis_b_tvalid && m_axis_b_tready) begin
        b_q.push_back({m_axis_b_tlast, m_axis_b_tdata});
      end
      if (m_axis_d_tvalid && m_axis_d_tready) begin
        d_q.push_back(m_axis_d_tdata);
      end
      if (m_axis_d_tvalid) begin
        compare_value("m_axis_d_tlast", m_axis_d_tlast, 1'b1);
      end
    end
  end

  // Offer one pair and leave it on the bus if refused
  task automatic send_pair(input operand_t l, input operand_t t, input logic ll,
                           input logic tl, input int limit, output bit taken);
    int  n;
    bit  rdy;
    s_axis_l_tdata  = l;
    s_axis_t_tdata  = t;
    s_axis_l_tlast  = ll;
    s_axis_t_tlast  = tl;
    s_axis_l_tvalid = 1'b1;
    s_axis_t_tvalid = 1'b1;
    taken = 0;
    n = 0;
    while (!taken && n < limit) begin
      @(negedge clk);
      rdy = s_axis_l_tready;
      expect_true(s_axis_t_tready == rdy, "left and top tready differ");
      @(posedge clk);
      #2;
      n++;
      taken = rdy;
    end
    if (taken) begin
      s_axis_l_tvalid = 1'b0;
      s_axis_t_tvalid = 1'b0;
      exp_r.push_back({ll, l});
      exp_b.push_back({tl, t});
      // Either tlast closes the vector
      model_acc   = model_first ? signed_product(l, t) : model_acc + signed_product(l, t);
      model_first = ll | tl;
      if (ll | tl) exp_d.push_back(model_acc);
    end
  endtask

  task automatic send_random(input logic ll, input logic tl);
    bit taken;
    send_pair(operand_t'($random(seed)), operand_t'($random(seed)), ll, tl, 100, taken);
    expect_true(taken, "pair was never accepted");
  endtask

  // Wait for all expected beats and a few idle cycles for extras
  task automatic drain_and_compare();
    int                waited;
    logic [OP_WIDTH:0] got;
    logic [OP_WIDTH:0] exp;
    waited = 0;
    while ((r_q.size() < exp_r.size() || b_q.size() < exp_b.size()
            || d_q.size() < exp_d.size()) && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    repeat (4) @(posedge clk);
    #2;
    expect_true(r_q.size() == exp_r.size(), "right beat count differs from left beats sent");
    expect_true(b_q.size() == exp_b.size(), "bottom beat count differs from top beats sent");
    expect_true(d_q.size() == exp_d.size(), "down result count differs from vectors sent");
    while (r_q.size() > 0 && exp_r.size() > 0) begin
      got = r_q.pop_front();
      exp = exp_r.pop_front();
      compare_value("m_axis_r_tdata", got[OP_WIDTH-1:0], exp[OP_WIDTH-1:0]);
      compare_value("m_axis_r_tlast", got[OP_WIDTH], exp[OP_WIDTH]);
    end
    while (b_q.size() > 0 && exp_b.size() > 0) begin
      got = b_q.pop_front();
      exp = exp_b.pop_front();
      compare_value("m_axis_b_tdata", got[OP_WIDTH-1:0], exp[OP_WIDTH-1:0]);
      compare_value("m_axis_b_tlast", got[OP_WIDTH], exp[OP_WIDTH]);
    end
    while (d_q.size() > 0 && exp_d.size() > 0) begin
      compare_value("m_axis_d_tdata", d_q.pop_front(), exp_d.pop_front());
    end
    r_q.delete();
    b_q.delete();
    d_q.delete();
    exp_r.delete();
    exp_b.delete();
    exp_d.delete();
  endtask

  task automatic pulse_reset();
    rst_req = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_req = 1'b0;
  endtask

  task automatic finish_test(string name);
    if (errors == 0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors);
    end
  endtask

  task automatic idle_outputs_low();
    compare_value("m_axis_r_tvalid", m_axis_r_tvalid, 1'b0);
    compare_value("m_axis_b_tvalid", m_axis_b_tvalid, 1'b0);
    compare_value("m_axis_d_tvalid", m_axis_d_tvalid, 1'b0);
    compare_value("err_unaligned", err_unaligned, 1'b0);
    compare_value("s_axis_l_tready", s_axis_l_tready, 1'b0);
    compare_value("s_axis_t_tready", s_axis_t_tready, 1'b0);
  endtask

  task automatic reset_state();
    errors = 0;
    // Registers settle at the first edge under sync reset
    @(posedge clk);
    while (!rst_n) begin
      @(negedge clk);
      idle_outputs_low();
    end
    @(posedge clk);
    #2;
    finish_test("reset state");
  endtask

  task automatic single_dot();
    errors = 0;
    for (int i = 0; i < 4; i++) send_random(i == 3, i == 3);
    drain_and_compare();
    finish_test("single dot product");
  endtask

  task automatic down_backpressure();
    operand_t l;
    operand_t t;
    bit       taken;
    bit       refused;
    errors  = 0;
    refused = 0;
    m_axis_d_tready = 1'b0;
    for (int i = 0; i < 6; i++) begin
      l = operand_t'($random(seed));
      t = operand_t'($random(seed));
      send_pair(l, t, 1'b1, 1'b1, 20, taken);
      if (!taken) begin
        refused = 1;
        // Only a full set of reserved result slots blocks a last pair
        expect_true(i == RESULT_DEPTH_DEFAULT,
                    "last pair refused at a result count other than the queue depth");
        m_axis_d_tready = 1'b1;
        send_pair(l, t, 1'b1, 1'b1, 100, taken);
        expect_true(taken, "refused pair not accepted after down was released");
      end
    end
    m_axis_d_tready = 1'b1;
    expect_true(refused, "no last pair was refused while down was stalled");
    drain_and_compare();
    finish_test("down back-pressure");
  endtask

  task automatic right_backpressure();
    operand_t l;
    operand_t t;
    bit       taken;
    bit       stopped;
    int       accepted;
    errors   = 0;
    stopped  = 0;
    accepted = 0;
    m_axis_r_tready = 1'b0;
    for (int i = 0; i < 4; i++) begin
      l = operand_t'($random(seed));
      t = operand_t'($random(seed));
      send_pair(l, t, i == 3, i == 3, stopped ? 100 : 10, taken);
      if (!taken && !stopped) begin
        stopped = 1;
        expect_true(accepted <= 2, "acceptance went on past two beats with right stalled");
        m_axis_r_tready = 1'b1;
        send_pair(l, t, i == 3, i == 3, 100, taken);
      end else if (!stopped) begin
        accepted++;
      end
      expect_true(taken, "pair not accepted after right was released");
    end
    m_axis_r_tready = 1'b1;
    expect_true(stopped, "acceptance never stopped with right stalled");
    drain_and_compare();
    finish_test("right back-pressure");
  endtask

  task automatic unaligned_last();
    errors = 0;
    send_random(1'b1, 1'b0);
    @(negedge clk);
    compare_value("err_unaligned", err_unaligned, 1'b1);
    drain_and_compare();
    // Clean vectors leave the flag set
    for (int i = 0; i < 4; i++) send_random(i % 2 == 1, i % 2 == 1);
    drain_and_compare();
    compare_value("err_unaligned", err_unaligned, 1'b1);
    pulse_reset();
    @(negedge clk);
    compare_value("err_unaligned", err_unaligned, 1'b0);
    @(posedge clk);
    #2;
    finish_test("unaligned last");
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst_req         = 1'b0;
    s_axis_l_tdata  = '0;
    s_axis_l_tvalid = 1'b0;
    s_axis_l_tlast  = 1'b0;
    s_axis_t_tdata  = '0;
    s_axis_t_tvalid = 1'b0;
    s_axis_t_tlast  = 1'b0;
    m_axis_r_tready = 1'b1;
    m_axis_b_tready = 1'b1;
    m_axis_d_tready = 1'b1;
    model_acc       = '0;
    model_first     = 1;
    tests_passed    = 0;
    tests_failed    = 0;
    reset_state();
    single_dot();
    down_backpressure();
    right_backpressure();
    unaligned_last();
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
